//--- Makefile
TOP = chan_est_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -o chan_est_sim
	./obj_dir/chan_est_sim > sim.log 2>&1; cat sim.log; grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+include
logic/dsp_pkg.sv
logic/csr_pkg.sv
logic/symbol_history.sv
logic/channel_filter.sv
logic/residual_monitor.sv
logic/est_csr.sv
logic/chan_est_top.sv
test/chan_est_tb.sv

//--- logic/chan_est_top.sv
`timescale 1ns/1ps

module chan_est_top #(
    parameter int lanes = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::axil_req_t axil,
    output csr_pkg::axil_rsp_t axil_rsp,
    input  logic               sym_valid,
    input  dsp_pkg::sym_t      sym_in [lanes],
    input  dsp_pkg::code_t     adc_in [lanes],
    output logic               est_valid,
    output dsp_pkg::code_t     est_code [lanes],
    output logic               err_valid,
    output dsp_pkg::err_t      err_code [lanes]
);

    dsp_pkg::tap_t   taps [dsp_pkg::depth];
    dsp_pkg::shift_t shifts [lanes];
    dsp_pkg::sym_t   window [dsp_pkg::depth-1+lanes];
    dsp_pkg::acc_t   err_sum;
    dsp_pkg::cnt_t   sample_count;
    logic            hist_shift;
    logic            window_valid;
    logic            stat_clear;

    est_csr #(.lanes(lanes)) u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .axil         (axil),
        .axil_rsp     (axil_rsp),
        .sym_valid    (sym_valid),
        .hist_shift   (hist_shift),
        .taps         (taps),
        .shifts       (shifts),
        .stat_clear   (stat_clear),
        .err_sum      (err_sum),
        .sample_count (sample_count)
    );

    symbol_history #(.lanes(lanes)) u_hist (
        .clk          (clk),
        .rst_n        (rst_n),
        .hist_shift   (hist_shift),
        .sym_in       (sym_in),
        .window       (window),
        .window_valid (window_valid)
    );

    channel_filter #(.lanes(lanes)) u_filt (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (window_valid),
        .window    (window),
        .taps      (taps),
        .shifts    (shifts),
        .est_valid (est_valid),
        .est_code  (est_code)
    );

    // ADC codes enter together with the decisions they belong to
    residual_monitor #(.lanes(lanes)) u_mon (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_valid    (hist_shift),
        .adc_in       (adc_in),
        .est_valid    (est_valid),
        .est_code     (est_code),
        .stat_clear   (stat_clear),
        .err_valid    (err_valid),
        .err_code     (err_code),
        .err_sum      (err_sum),
        .sample_count (sample_count)
    );

endmodule

//--- logic/channel_filter.sv
`timescale 1ns/1ps

module channel_filter #(
    parameter int lanes = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  dsp_pkg::sym_t   window [dsp_pkg::depth-1+lanes],
    input  dsp_pkg::tap_t   taps [dsp_pkg::depth],
    input  dsp_pkg::shift_t shifts [lanes],
    output logic            est_valid,
    output dsp_pkg::code_t  est_code [lanes]
);

    // lane 0's newest symbol
    localparam int newest   = dsp_pkg::depth - 1;
    localparam int mp_first = dsp_pkg::hp_depth;
    localparam int lp_first = dsp_pkg::hp_depth + dsp_pkg::mp_depth;
    // worst case is about 3300, so 16 bits leave headroom
    localparam int sum_w = 16;

    typedef logic signed [sum_w-1:0] sum_t;

    logic signed [dsp_pkg::mp_bits-1:0] mp_tap [dsp_pkg::mp_depth];
    logic signed [dsp_pkg::lp_bits-1:0] lp_tap [dsp_pkg::lp_depth];
    sum_t hp_sum [lanes];
    sum_t mp_sum [lanes];
    sum_t lp_sum [lanes];
    sum_t scaled [lanes];

    // reduced taps keep only their low bits, still read as signed
    always_comb begin
        for (int j = 0; j < dsp_pkg::mp_depth; j++) begin
            mp_tap[j] = taps[mp_first+j][dsp_pkg::mp_bits-1:0];
        end
        for (int j = 0; j < dsp_pkg::lp_depth; j++) begin
            lp_tap[j] = taps[lp_first+j][dsp_pkg::lp_bits-1:0];
        end
    end

    // tap j meets window element i + depth - 1 - j
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            hp_sum[i] = '0;
            mp_sum[i] = '0;
            lp_sum[i] = '0;
            for (int j = 0; j < dsp_pkg::hp_depth; j++) begin
                hp_sum[i] = hp_sum[i] + window[i+newest-j] * taps[j];
            end
            for (int j = 0; j < dsp_pkg::mp_depth; j++) begin
                mp_sum[i] = mp_sum[i] + window[i+newest-mp_first-j] * mp_tap[j];
            end
            for (int j = 0; j < dsp_pkg::lp_depth; j++) begin
                lp_sum[i] = lp_sum[i] + window[i+newest-lp_first-j] * lp_tap[j];
            end
            scaled[i] = (hp_sum[i] + mp_sum[i] + lp_sum[i]) >>> shifts[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            est_valid <= 1'b0;
        end else begin
            est_valid <= in_valid;
        end
    end

    // the estimate wraps to its low 8 bits
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < lanes; i++) begin
                est_code[i] <= scaled[i][7:0];
            end
        end
    end

    // decisions coming through the history must be PAM4 levels
    for (genvar k = 0; k < dsp_pkg::depth - 1 + lanes; k++) begin : g_sym_chk
        a_sym_level: assert property (@(posedge clk) disable iff (!rst_n)
            window[k] inside {-3, -1, 1, 3});
    end

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0] resp_t;

    // master side of the AXI4-Lite port
    typedef struct packed {
        logic       awvalid;
        addr_t      awaddr;
        logic       wvalid;
        data_t      wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        addr_t      araddr;
        logic       rready;
    } axil_req_t;

    // slave side of the AXI4-Lite port
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axil_rsp_t;

    // bit 0 enable, bit 1 clear (self-clearing)
    localparam addr_t addr_ctrl     = 12'h000;
    // two bits per lane, lane 0 in the low bits
    localparam addr_t addr_shift    = 12'h004;
    localparam addr_t addr_err_sum  = 12'h008;
    localparam addr_t addr_count    = 12'h00C;
    // tap k at base + 4k
    localparam addr_t addr_tap_base = 12'h100;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

endpackage

//--- logic/dsp_pkg.sv
package dsp_pkg;

    // PAM4 level, one of -3, -1, +1, +3
    typedef logic signed [2:0] sym_t;
    typedef logic signed [7:0] tap_t;
    // ADC code and estimated code share one format
    typedef logic signed [7:0] code_t;
    typedef logic signed [8:0] err_t;
    typedef logic [31:0] acc_t;
    typedef logic [31:0] cnt_t;
    // per-lane arithmetic right shift of the filter sum
    typedef logic [1:0] shift_t;

    // channel model length
    localparam int depth = 30;

    // tap segments, ordered from the main cursor outwards
    localparam int hp_depth = 6;
    localparam int mp_depth = 6;
    localparam int lp_depth = 18;

    // tap bits kept in the mid and low precision segments
    localparam int mp_bits = 6;
    localparam int lp_bits = 4;

endpackage

//--- logic/est_csr.sv
`timescale 1ns/1ps

module est_csr #(
    parameter int lanes = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::axil_req_t axil,
    output csr_pkg::axil_rsp_t axil_rsp,
    input  logic               sym_valid,
    output logic               hist_shift,
    output dsp_pkg::tap_t      taps [dsp_pkg::depth],
    output dsp_pkg::shift_t    shifts [lanes],
    output logic               stat_clear,
    input  dsp_pkg::acc_t      err_sum,
    input  dsp_pkg::cnt_t      sample_count
);

    localparam int idx_w = $clog2(dsp_pkg::depth);
    localparam csr_pkg::addr_t tap_end = csr_pkg::addr_tap_base + 12'(4 * dsp_pkg::depth);

    logic           enable;
    logic           wr_fire;
    logic           rd_fire;
    logic           bvalid;
    logic           rvalid;
    csr_pkg::resp_t bresp;
    csr_pkg::resp_t rresp;
    csr_pkg::data_t rdata;
    csr_pkg::data_t shift_word;
    csr_pkg::data_t wmask;
    csr_pkg::data_t ctrl_wr;
    csr_pkg::data_t shift_wr;
    csr_pkg::data_t tap_wr;
    csr_pkg::addr_t aw_off;
    csr_pkg::addr_t ar_off;

    function automatic logic is_tap(input csr_pkg::addr_t addr);
        return addr >= csr_pkg::addr_tap_base && addr < tap_end && addr[1:0] == 2'b00;
    endfunction

    // byte lanes not strobed keep their old value
    function automatic csr_pkg::data_t merge(input csr_pkg::data_t old_val,
                                             input csr_pkg::data_t new_val,
                                             input csr_pkg::data_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // a pending response holds off the next request on its own channel
    assign wr_fire    = axil.awvalid && axil.wvalid && !bvalid;
    assign rd_fire    = axil.arvalid && !rvalid;
    assign hist_shift = sym_valid && enable;
    assign aw_off     = axil.awaddr - csr_pkg::addr_tap_base;
    assign ar_off     = axil.araddr - csr_pkg::addr_tap_base;

    always_comb begin
        shift_word = '0;
        for (int i = 0; i < lanes; i++) begin
            shift_word[2*i +: 2] = shifts[i];
        end
        for (int b = 0; b < 4; b++) begin
            wmask[8*b +: 8] = {8{axil.wstrb[b]}};
        end
    end

    assign ctrl_wr  = merge({31'd0, enable}, axil.wdata, wmask);
    assign shift_wr = merge(shift_word, axil.wdata, wmask);
    assign tap_wr   = merge({24'd0, taps[aw_off[idx_w+1:2]]}, axil.wdata, wmask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            stat_clear <= 1'b0;
            taps       <= '{default: '0};
            shifts     <= '{default: '0};
            bvalid     <= 1'b0;
            bresp      <= csr_pkg::resp_okay;
        end else begin
            stat_clear <= 1'b0;
            if (bvalid && axil.bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= csr_pkg::resp_okay;
                case (axil.awaddr)
                    csr_pkg::addr_ctrl: begin
                        enable     <= ctrl_wr[0];
                        stat_clear <= ctrl_wr[1];
                    end
                    csr_pkg::addr_shift: begin
                        for (int i = 0; i < lanes; i++) begin
                            shifts[i] <= shift_wr[2*i +: 2];
                        end
                    end
                    default: begin
                        // statistics are read-only, everything else unmapped
                        if (is_tap(axil.awaddr)) begin
                            taps[aw_off[idx_w+1:2]] <= tap_wr[7:0];
                        end else begin
                            bresp <= csr_pkg::resp_slverr;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= csr_pkg::resp_okay;
            rdata  <= '0;
        end else begin
            if (rvalid && axil.rready) begin
                rvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= csr_pkg::resp_okay;
                case (axil.araddr)
                    csr_pkg::addr_ctrl:    rdata <= {31'd0, enable};
                    csr_pkg::addr_shift:   rdata <= shift_word;
                    csr_pkg::addr_err_sum: rdata <= err_sum;
                    csr_pkg::addr_count:   rdata <= sample_count;
                    default: begin
                        rdata <= {24'd0, taps[ar_off[idx_w+1:2]]};
                        if (!is_tap(axil.araddr)) begin
                            rdata <= '0;
                            rresp <= csr_pkg::resp_slverr;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = rd_fire;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !axil.bready |=> bvalid && $stable(bresp));
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !axil.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- logic/residual_monitor.sv
`timescale 1ns/1ps

module residual_monitor #(
    parameter int lanes = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           adc_valid,
    input  dsp_pkg::code_t adc_in [lanes],
    input  logic           est_valid,
    input  dsp_pkg::code_t est_code [lanes],
    input  logic           stat_clear,
    output logic           err_valid,
    output dsp_pkg::err_t  err_code [lanes],
    output dsp_pkg::acc_t  err_sum,
    output dsp_pkg::cnt_t  sample_count
);

    logic           adc_v1;
    logic           adc_v2;
    dsp_pkg::code_t adc_d1 [lanes];
    dsp_pkg::code_t adc_d2 [lanes];
    dsp_pkg::acc_t  abs_sum;
    logic [32:0]    sum_next;
    logic [32:0]    cnt_next;

    // two stages line the ADC codes up with the estimate
    always_ff @(posedge clk) begin
        if (adc_valid) begin
            adc_d1 <= adc_in;
        end
        if (adc_v1) begin
            adc_d2 <= adc_d1;
        end
        if (est_valid) begin
            for (int i = 0; i < lanes; i++) begin
                err_code[i] <= dsp_pkg::err_t'(adc_d2[i]) - dsp_pkg::err_t'(est_code[i]);
            end
        end
    end

    // |err| never exceeds 255, so negation cannot overflow
    always_comb begin
        abs_sum = '0;
        for (int i = 0; i < lanes; i++) begin
            abs_sum = abs_sum + dsp_pkg::acc_t'(err_code[i] < 0 ? -err_code[i] : err_code[i]);
        end
    end

    assign sum_next = {1'b0, err_sum} + {1'b0, abs_sum};
    assign cnt_next = {1'b0, sample_count} + 33'(lanes);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adc_v1       <= 1'b0;
            adc_v2       <= 1'b0;
            err_valid    <= 1'b0;
            err_sum      <= '0;
            sample_count <= '0;
        end else begin
            adc_v1    <= adc_valid;
            adc_v2    <= adc_v1;
            err_valid <= est_valid;
            if (stat_clear) begin
                err_sum      <= '0;
                sample_count <= '0;
            end else if (err_valid) begin
                // both counters stick at all ones
                err_sum      <= sum_next[32] ? '1 : sum_next[31:0];
                sample_count <= cnt_next[32] ? '1 : cnt_next[31:0];
            end
        end
    end

    // an estimate without its ADC group means the pipelines slipped
    a_adc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        est_valid |-> adc_v2);

endmodule

//--- logic/symbol_history.sv
`timescale 1ns/1ps

module symbol_history #(
    parameter int lanes = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          hist_shift,
    input  dsp_pkg::sym_t sym_in [lanes],
    output dsp_pkg::sym_t window [dsp_pkg::depth-1+lanes],
    output logic          window_valid
);

    // symbols carried over from earlier groups
    localparam int keep = dsp_pkg::depth - 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // +1 is a legal PAM4 level, so the filter sees a clean start
            window       <= '{default: dsp_pkg::sym_t'(1)};
            window_valid <= 1'b0;
        end else begin
            window_valid <= hist_shift;
            if (hist_shift) begin
                // oldest group falls out at index 0
                for (int k = 0; k < keep; k++) begin
                    window[k] <= window[k+lanes];
                end
                for (int i = 0; i < lanes; i++) begin
                    window[keep+i] <= sym_in[i];
                end
            end
        end
    end

endmodule

//--- include/chan_est_model.svh
`ifndef CHAN_EST_MODEL_SVH
`define CHAN_EST_MODEL_SVH

// galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

// two random bits to a PAM4 level
function automatic dsp_pkg::sym_t sym_from_bits(input logic [1:0] bits);
    return dsp_pkg::sym_t'(2 * int'(bits) - 3);
endfunction

// tap value as the filter sees it after segment reduction
function automatic int model_tap(input dsp_pkg::tap_t taps [dsp_pkg::depth], input int j);
    if (j < dsp_pkg::hp_depth) begin
        return int'(taps[j]);
    end else if (j < dsp_pkg::hp_depth + dsp_pkg::mp_depth) begin
        return int'(signed'(taps[j][dsp_pkg::mp_bits-1:0]));
    end
    return int'(signed'(taps[j][dsp_pkg::lp_bits-1:0]));
endfunction

// hist holds depth-1+lanes symbols, oldest first
function automatic dsp_pkg::code_t model_estimate(input dsp_pkg::sym_t hist [$],
                                                  input int lane,
                                                  input dsp_pkg::tap_t taps [dsp_pkg::depth],
                                                  input dsp_pkg::shift_t shift);
    int acc;
    acc = 0;
    for (int j = 0; j < dsp_pkg::depth; j++) begin
        acc = acc + int'(hist[lane+dsp_pkg::depth-1-j]) * model_tap(taps, j);
    end
    acc = acc >>> shift;
    return dsp_pkg::code_t'(acc);
endfunction

function automatic dsp_pkg::err_t model_error(input dsp_pkg::code_t adc,
                                              input dsp_pkg::code_t est);
    return dsp_pkg::err_t'(int'(adc) - int'(est));
endfunction

`endif

//--- test/chan_est_tb.sv
`timescale 1ns/1ps

module chan_est_tb;

    localparam int lanes    = 4;
    localparam int timeout  = 100;
    localparam int hist_len = dsp_pkg::depth - 1 + lanes;

    // expected outputs of one accepted group and the cycle they are due
    typedef struct packed {
        int                         due;
        dsp_pkg::code_t [lanes-1:0] est;
        dsp_pkg::err_t  [lanes-1:0] err;
    } expect_t;

    logic               clk;
    logic               rst_n;
    csr_pkg::axil_req_t axil;
    csr_pkg::axil_rsp_t axil_rsp;
    logic               sym_valid;
    dsp_pkg::sym_t      sym_in [lanes];
    dsp_pkg::code_t     adc_in [lanes];
    logic               est_valid;
    dsp_pkg::code_t     est_code [lanes];
    logic               err_valid;
    dsp_pkg::err_t      err_code [lanes];

    logic [31:0]     lfsr;
    int              cyc;
    int              abs_sum_m;
    int              groups_m;
    logic            enable_m;
    string           test_name;
    dsp_pkg::tap_t   taps_m [dsp_pkg::depth];
    dsp_pkg::shift_t shifts_m [lanes];
    dsp_pkg::sym_t   hist_m [$];
    expect_t         est_q [$];
    expect_t         err_q [$];

    `include "chan_est_model.svh"

    chan_est_top #(.lanes(lanes)) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil      (axil),
        .axil_rsp  (axil_rsp),
        .sym_valid (sym_valid),
        .sym_in    (sym_in),
        .adc_in    (adc_in),
        .est_valid (est_valid),
        .est_code  (est_code),
        .err_valid (err_valid),
        .err_code  (err_code)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_mismatch(input string what, input int exp_val, input int act_val);
        $display("Fail %s %s expected %0d actual %0d", test_name, what, exp_val, act_val);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error in %s: %s", test_name, what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // one LFSR step per bit taken, newest bit lowest
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    // 0 awready, 1 bvalid, 2 arready, 3 rvalid, otherwise scoreboard empty
    function automatic logic flag_set(input int sel);
        case (sel)
            0: return axil_rsp.awready;
            1: return axil_rsp.bvalid;
            2: return axil_rsp.arready;
            3: return axil_rsp.rvalid;
            default: return est_q.size() == 0 && err_q.size() == 0;
        endcase
    endfunction

    task automatic wait_flag(input int sel, input string what);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (!flag_set(sel)) begin
            wait_cnt++;
            if (wait_cnt >= timeout) begin
                report_error(what);
            end
            @(negedge clk);
        end
    endtask

    task automatic axil_write(input csr_pkg::addr_t addr, input csr_pkg::data_t data,
                              output csr_pkg::resp_t resp);
        int hold;
        axil.awvalid = 1'b1;
        axil.awaddr  = addr;
        axil.wvalid  = 1'b1;
        axil.wdata   = data;
        axil.wstrb   = 4'hF;
        wait_flag(0, "write address and data were never accepted");
        assert (axil_rsp.wready) else begin
            report_error("wready did not pulse together with awready");
        end
        @(posedge clk);
        #0.5;
        axil.awvalid = 1'b0;
        axil.wvalid  = 1'b0;
        wait_flag(1, "write response never arrived");
        resp = axil_rsp.bresp;
        // bready stays low for a random stretch
        hold = int'(rand_bits(3));
        repeat (hold) begin
            @(negedge clk);
            assert (axil_rsp.bvalid && axil_rsp.bresp == resp) else begin
                report_error("write response dropped or changed while bready was low");
            end
        end
        @(posedge clk);
        #0.5;
        axil.bready = 1'b1;
        @(posedge clk);
        #0.5;
        axil.bready = 1'b0;
    endtask

    task automatic axil_read(input csr_pkg::addr_t addr, output csr_pkg::data_t data,
                             output csr_pkg::resp_t resp);
        int hold;
        axil.arvalid = 1'b1;
        axil.araddr  = addr;
        wait_flag(2, "read address was never accepted");
        @(posedge clk);
        #0.5;
        axil.arvalid = 1'b0;
        wait_flag(3, "read data never arrived");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        hold = int'(rand_bits(3));
        repeat (hold) begin
            @(negedge clk);
            assert (axil_rsp.rvalid && axil_rsp.rdata == data && axil_rsp.rresp == resp) else begin
                report_error("read response dropped or changed while rready was low");
            end
        end
        @(posedge clk);
        #0.5;
        axil.rready = 1'b1;
        @(posedge clk);
        #0.5;
        axil.rready = 1'b0;
    endtask

    task automatic write_ok(input csr_pkg::addr_t addr, input csr_pkg::data_t data);
        csr_pkg::resp_t resp;
        axil_write(addr, data, resp);
        assert (resp == csr_pkg::resp_okay) else begin
            report_mismatch("bresp", int'(csr_pkg::resp_okay), int'(resp));
        end
    endtask

    task automatic read_check(input string what, input csr_pkg::addr_t addr,
                              input csr_pkg::data_t exp_val);
        csr_pkg::data_t data;
        csr_pkg::resp_t resp;
        axil_read(addr, data, resp);
        assert (resp == csr_pkg::resp_okay) else begin
            report_mismatch({what, " rresp"}, int'(csr_pkg::resp_okay), int'(resp));
        end
        assert (data == exp_val) else begin
            report_mismatch(what, int'(exp_val), int'(data));
        end
    endtask

    // drives one group per cycle, the model follows only accepted groups
    task automatic send_groups(input int n);
        expect_t e;
        for (int g = 0; g < n; g++) begin
            sym_valid = 1'b1;
            for (int i = 0; i < lanes; i++) begin
                sym_in[i] = sym_from_bits(2'(rand_bits(2)));
                adc_in[i] = dsp_pkg::code_t'(rand_bits(8));
            end
            if (enable_m) begin
                for (int i = 0; i < lanes; i++) begin
                    void'(hist_m.pop_front());
                    hist_m.push_back(sym_in[i]);
                end
                for (int i = 0; i < lanes; i++) begin
                    e.est[i] = model_estimate(hist_m, i, taps_m, shifts_m[i]);
                    e.err[i] = model_error(adc_in[i], e.est[i]);
                    abs_sum_m += (int'(e.err[i]) < 0) ? -int'(e.err[i]) : int'(e.err[i]);
                end
                e.due = cyc + 2;
                est_q.push_back(e);
                e.due = cyc + 3;
                err_q.push_back(e);
                groups_m++;
            end
            @(posedge clk);
            #0.5;
        end
        sym_valid = 1'b0;
    endtask

    // scoreboard, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (est_valid) begin
                assert (est_q.size() > 0) else report_error("est_valid with no accepted group");
                assert (est_q[0].due == cyc) else report_mismatch("est latency", est_q[0].due, cyc);
                for (int i = 0; i < lanes; i++) begin
                    assert (est_code[i] == est_q[0].est[i]) else begin
                        report_mismatch($sformatf("est_code[%0d]", i), int'(est_q[0].est[i]),
                                        int'(est_code[i]));
                    end
                end
                void'(est_q.pop_front());
            end else if (est_q.size() > 0 && est_q[0].due <= cyc) begin
                report_error("est_valid did not arrive 2 cycles after an accepted group");
            end
            if (err_valid) begin
                assert (err_q.size() > 0) else report_error("err_valid with no accepted group");
                assert (err_q[0].due == cyc) else report_mismatch("err latency", err_q[0].due, cyc);
                for (int i = 0; i < lanes; i++) begin
                    assert (err_code[i] == err_q[0].err[i]) else begin
                        report_mismatch($sformatf("err_code[%0d]", i), int'(err_q[0].err[i]),
                                        int'(err_code[i]));
                    end
                end
                void'(err_q.pop_front());
            end else if (err_q.size() > 0 && err_q[0].due <= cyc) begin
                report_error("err_valid did not arrive 3 cycles after an accepted group");
            end
        end
    end

    initial begin
        csr_pkg::data_t shift_word;
        csr_pkg::data_t data;
        csr_pkg::resp_t resp;
        int             k;
        clk       = 1'b0;
        rst_n     = 1'b0;
        axil      = '0;
        sym_valid = 1'b0;
        for (int i = 0; i < lanes; i++) begin
            sym_in[i]   = dsp_pkg::sym_t'(1);
            adc_in[i]   = '0;
            shifts_m[i] = '0;
        end
        for (int j = 0; j < dsp_pkg::depth; j++) begin
            taps_m[j] = '0;
        end
        // history matches the reset state of the window
        for (int j = 0; j < hist_len; j++) begin
            hist_m.push_back(dsp_pkg::sym_t'(1));
        end
        lfsr      = 32'd70713;
        cyc       = 0;
        abs_sum_m = 0;
        groups_m  = 0;
        enable_m  = 1'b0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        test_name = "register access";
        for (int j = 0; j < dsp_pkg::depth; j++) begin
            taps_m[j] = dsp_pkg::tap_t'(rand_bits(8));
            write_ok(csr_pkg::addr_tap_base + 12'(4 * j), {24'd0, taps_m[j]});
        end
        shift_word = '0;
        for (int i = 0; i < lanes; i++) begin
            shifts_m[i] = dsp_pkg::shift_t'(rand_bits(2));
            shift_word[2*i +: 2] = shifts_m[i];
        end
        write_ok(csr_pkg::addr_shift, shift_word);
        for (int j = 0; j < dsp_pkg::depth; j++) begin
            read_check($sformatf("tap %0d", j), csr_pkg::addr_tap_base + 12'(4 * j),
                       {24'd0, taps_m[j]});
        end
        read_check("shift", csr_pkg::addr_shift, shift_word);
        axil_write(csr_pkg::addr_err_sum, 32'h0000_1234, resp);
        assert (resp == csr_pkg::resp_slverr) else begin
            report_mismatch("read-only bresp", int'(csr_pkg::resp_slverr), int'(resp));
        end
        axil_read(12'h050, data, resp);
        assert (resp == csr_pkg::resp_slverr) else begin
            report_mismatch("unmapped rresp", int'(csr_pkg::resp_slverr), int'(resp));
        end

        test_name = "estimate and residual";
        write_ok(csr_pkg::addr_ctrl, 32'h1);
        enable_m = 1'b1;
        send_groups(200);
        wait_flag(4, "estimates or residuals of the stream did not arrive");
        @(posedge clk);
        #0.5;

        test_name = "statistics";
        read_check("err_sum", csr_pkg::addr_err_sum, abs_sum_m);
        read_check("sample_count", csr_pkg::addr_count, 32'(lanes * groups_m));
        write_ok(csr_pkg::addr_ctrl, 32'h3);
        abs_sum_m = 0;
        groups_m  = 0;
        read_check("cleared err_sum", csr_pkg::addr_err_sum, 32'd0);
        read_check("cleared sample_count", csr_pkg::addr_count, 32'd0);

        test_name = "enable gating";
        write_ok(csr_pkg::addr_ctrl, 32'h0);
        enable_m = 1'b0;
        send_groups(20);
        // the scoreboard flags any stray est_valid here
        repeat (5) @(posedge clk);
        #0.5;
        write_ok(csr_pkg::addr_ctrl, 32'h1);
        enable_m = 1'b1;
        send_groups(20);
        wait_flag(4, "estimates after re-enabling did not arrive");
        @(posedge clk);
        #0.5;
        read_check("gated sample_count", csr_pkg::addr_count, 32'(lanes * groups_m));
        read_check("gated err_sum", csr_pkg::addr_err_sum, abs_sum_m);

        test_name = "back-pressure";
        for (int n = 0; n < 8; n++) begin
            k = int'(rand_bits(5)) % dsp_pkg::depth;
            read_check($sformatf("tap %0d", k), csr_pkg::addr_tap_base + 12'(4 * k),
                       {24'd0, taps_m[k]});
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
